// ==== list.f ====
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/bpu.sv
hw/ifu.sv
hw/if_id_reg.sv
hw/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_checker.sv
verif/tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert --top-module tb_fetch_top -f list.f -o sim_fetch \
  > build.log 2>&1 \
  && ./obj_dir/sim_fetch > sim.log 2>&1 \
  || echo "build or simulation stopped early" >> sim.log

cat sim.log
if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
  exit 1
fi
exit 0

// ==== verif/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam int unsigned HISLEN      = 8;
  localparam int unsigned BTB_ENTRIES = 16;
  localparam int unsigned RAS_DEPTH   = 4;
  localparam int N_CYCLES = 4000;
  localparam int WAIT_MAX = 200;

  logic clk, rst_n_i, done;
  logic [XLEN-1:0] inst_addr_o, if_rdata_i;
  logic if_rdata_valid_i, ex_branch_valid_i, ex_branch_taken_i;
  logic [XLEN-1:0] ex_pc_i, ex_target_i, ex_redirect_pc_i, id_ras_push_data_i;
  logic [HISLEN-1:0] ex_history_i, id_history_o;
  jump_type_e ex_jump_type_i;
  logic ex_redirect_i, id_ras_push_valid_i, id_stall_i;
  logic id_valid_o, id_pdt_taken_o;
  logic [XLEN-1:0] id_pc_o, id_inst_o;
  logic [TRAP_LEN-1:0] id_trap_o;
  logic [31:0] mem [64];  // program image, wraps every 256 bytes
  int errs, checks, tries;
  int total_errs;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign if_rdata_i = mem[inst_addr_o[7:2]];

  fetch_top #(
    .RESET_PC (RESET_PC), .HISLEN (HISLEN), .BTB_ENTRIES (BTB_ENTRIES), .RAS_DEPTH (RAS_DEPTH)
  ) u_fetch_top (.*);

  fetch_checker #(
    .RESET_PC (RESET_PC), .HISLEN (HISLEN), .BTB_ENTRIES (BTB_ENTRIES), .RAS_DEPTH (RAS_DEPTH)
  ) u_checker (.*, .done_i (done), .err_cnt_o (errs), .chk_cnt_o (checks));

  bind if_id_reg fetch_properties u_props (
    .clk (clk), .rst_n_i (rst_n_i), .stall_i (stall_i), .flush_i (flush_i),
    .id_valid_o (id_valid_o), .id_pdt_taken_o (id_pdt_taken_o), .id_pc_o (id_pc_o),
    .id_inst_o (id_inst_o), .id_trap_o (id_trap_o)
  );

  // mostly ALU ops, some jal, branches and returns
  function automatic logic [31:0] random_word();
    logic [31:0] r, imm;
    r   = $urandom;
    imm = 32'(($urandom % 32) * 4) - 32'd64;  // short jumps, -64 to +60
    if (r[3:0] < 4'd11) return {r[31:7], 7'b0110011};
    if (r[3:0] < 4'd13) return {imm[20], imm[10:1], imm[11], imm[19:12], r[11:7], 7'b1101111};
    if (r[3:0] < 4'd15) return {r[31:7], 7'b1100011};
    return 32'h0000_8067;  // jalr x0, 0(x1)
  endfunction

  task automatic drive_random();
    logic [31:0] r1, r2;
    r1 = $urandom;
    r2 = $urandom;
    if_rdata_valid_i    <= ($urandom % 10) < 8;
    id_stall_i          <= ($urandom % 10) == 0;
    ex_redirect_i       <= ($urandom % 40) == 0;
    ex_redirect_pc_i    <= (r1[31:29] == 3'd0) ? {24'b0, r1[7:0]} : {24'b0, r1[7:2], 2'b0};
    ex_branch_valid_i   <= r1[28:27] == 2'd0;
    ex_branch_taken_i   <= r1[26:25] != 2'd0;
    ex_jump_type_i      <= (r1[24:23] == 2'd0) ? JT_JAL : JT_BRANCH;
    ex_pc_i             <= {24'b0, r2[7:2], 2'b0};
    ex_target_i         <= {24'b0, r2[15:10], 2'b0};
    ex_history_i        <= id_history_o;  // train with the history decode saw
    id_ras_push_valid_i <= r2[19:16] == 4'd0;
    id_ras_push_data_i  <= {24'b0, r2[27:22], 2'b0};
  endtask

  initial begin
    void'($urandom(10));
    foreach (mem[i]) mem[i] = random_word();
    done = 1'b0;
    rst_n_i = 1'b0;
    if_rdata_valid_i = 1'b0;
    ex_branch_valid_i = 1'b0;
    ex_branch_taken_i = 1'b0;
    ex_pc_i = '0;
    ex_target_i = '0;
    ex_history_i = '0;
    ex_jump_type_i = JT_NONE;
    ex_redirect_i = 1'b0;
    ex_redirect_pc_i = '0;
    id_ras_push_valid_i = 1'b0;
    id_ras_push_data_i = '0;
    id_stall_i = 1'b0;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    if_rdata_valid_i <= 1'b1;
    tries = 0;
    while (!id_valid_o && tries < WAIT_MAX) begin
      @(posedge clk);
      tries++;
    end
    if (tries == WAIT_MAX) $display("no valid decode entry arrived after reset");
    for (int c = 0; c < N_CYCLES; c++) begin
      @(posedge clk);
      drive_random();
    end
    @(posedge clk);
    done <= 1'b1;
    @(negedge clk);
    total_errs = errs + u_fetch_top.u_if_id_reg.u_props.fail_cnt + int'(tries == WAIT_MAX);
    $display("checks %0d  errors %0d", checks, total_errs);
    if (total_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // run limit
  initial begin
    for (int t = 0; t < N_CYCLES + 2 * WAIT_MAX; t++) begin
      @(posedge clk);
    end
    $display("simulation ran past its cycle limit");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== verif/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = '0,
  parameter int unsigned                HISLEN      = 8,
  parameter int unsigned                BTB_ENTRIES = 16,
  parameter int unsigned                RAS_DEPTH   = 4
) (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic                           done_i,
  input  logic [fetch_pkg::XLEN-1:0]     inst_addr_o,
  input  logic [fetch_pkg::XLEN-1:0]     if_rdata_i,
  input  logic                           id_stall_i,
  input  logic                           ex_redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]     ex_redirect_pc_i,
  input  logic                           ex_branch_valid_i,
  input  logic                           ex_branch_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]     ex_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]     ex_target_i,
  input  logic [HISLEN-1:0]              ex_history_i,
  input  fetch_pkg::jump_type_e          ex_jump_type_i,
  input  logic                           id_ras_push_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]     id_ras_push_data_i,
  input  logic                           id_valid_o,
  input  logic [fetch_pkg::XLEN-1:0]     id_pc_o,
  input  logic [fetch_pkg::XLEN-1:0]     id_inst_o,
  input  logic [fetch_pkg::TRAP_LEN-1:0] id_trap_o,
  input  logic                           id_pdt_taken_o,
  input  logic [HISLEN-1:0]              id_history_o,
  output int                             err_cnt_o,
  output int                             chk_cnt_o
);
  import fetch_pkg::*;

  localparam int BI = $clog2(BTB_ENTRIES);
  localparam int N_TESTS = 9;
  localparam int T_RESET = 0, T_SEQ = 1, T_JAL = 2, T_RAS = 3;
  localparam int T_BR = 4, T_STALL = 5, T_REDIR = 6, T_TRAP = 7, T_FETCH = 8;

  string       names [N_TESTS];
  int          pass_cnt [N_TESTS];
  int          fail_cnt [N_TESTS];
  int          pht [1 << HISLEN];  // model counters
  logic        btb_v [BTB_ENTRIES];
  logic [31:0] btb_tag [BTB_ENTRIES];
  logic [31:0] btb_tgt [BTB_ENTRIES];
  logic [31:0] ras [$];
  logic [31:0] exp_pc;
  int          exp_src;
  logic        prev_stall, prev_redir;
  logic [31:0] prev_pc, prev_inst, prev_misc;
  logic [31:0] prev_word;  // memory word at the fetch address
  // training seen one sample earlier, applied a cycle late
  logic        tr_bv, tr_tk, tr_push;
  logic [31:0] tr_pc, tr_tgt, tr_data;
  logic [HISLEN-1:0] tr_hist;
  jump_type_e  tr_jt;

  initial begin
    names = '{"reset_pc", "sequential", "jal", "ras_return", "branch_btb",
              "stall_hold", "redirect", "trap", "fetch"};
    foreach (pht[i]) pht[i] = 1;
    foreach (btb_v[i]) btb_v[i] = 1'b0;
    foreach (pass_cnt[i]) begin
      pass_cnt[i] = 0;
      fail_cnt[i] = 0;
    end
    exp_pc     = RESET_PC;
    exp_src    = T_RESET;
    prev_stall = 1'b0;
    prev_redir = 1'b0;
    tr_bv      = 1'b0;
    tr_push    = 1'b0;
    err_cnt_o  = 0;
    chk_cnt_o  = 0;
  end

  function automatic logic [31:0] j_offset(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  task automatic compare(input int t, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt_o++;
    if (exp !== act) begin
      fail_cnt[t]++;
      err_cnt_o++;
      $display("[FAIL] %s expected %h actual %h", names[t], exp, act);
    end else begin
      pass_cnt[t]++;
    end
  endtask

  always @(negedge clk) begin
    logic [31:0] misc, nxt;
    logic        pred;
    int          src, idx, bi;
    misc = {6'b0, id_valid_o, id_pdt_taken_o, id_trap_o, id_history_o};
    if (rst_n_i && !done_i) begin
      if (prev_stall && !prev_redir) begin
        compare(T_STALL, prev_pc, id_pc_o);
        compare(T_STALL, prev_inst, id_inst_o);
        compare(T_STALL, prev_misc, misc);
      end else if (id_valid_o) begin
        compare(exp_src, exp_pc, id_pc_o);
        compare(T_FETCH, prev_word, id_inst_o);
        compare(T_TRAP, 32'(id_pc_o[1:0] != 2'b00), 32'(id_trap_o));
        pred = 1'b0;
        nxt  = id_pc_o + 32'd4;
        src  = T_SEQ;
        if (id_pc_o[1:0] == 2'b00) begin  // misaligned fetch never predicts
          case (id_inst_o[6:0])
            7'b1101111: begin
              pred = 1'b1;
              nxt  = id_pc_o + j_offset(id_inst_o);
              src  = T_JAL;
            end
            7'b1100011: begin
              idx = int'(id_pc_o[HISLEN+1:2] ^ id_history_o);
              bi  = int'(id_pc_o[BI+1:2]);
              src = T_BR;
              if (pht[idx] >= 2 && btb_v[bi] && btb_tag[bi] == (id_pc_o >> (BI + 2))) begin
                pred = 1'b1;
                nxt  = btb_tgt[bi];
              end
            end
            7'b1100111: begin
              if (id_inst_o[19:15] == 5'd1 && id_inst_o[11:7] == 5'd0 && ras.size() > 0) begin
                pred = 1'b1;
                nxt  = ras.pop_back();
                src  = T_RAS;
              end
            end
            default: pred = 1'b0;
          endcase
        end
        compare(src, 32'(pred), 32'(id_pdt_taken_o));
        exp_pc  = nxt;
        exp_src = src;
      end
      compare(T_FETCH, exp_pc, inst_addr_o);  // PC sits on the next decode entry
      if (ex_redirect_i) begin
        exp_pc  = ex_redirect_pc_i;
        exp_src = T_REDIR;
      end
      if (tr_bv && tr_jt == JT_BRANCH) begin
        idx = int'(tr_pc[HISLEN+1:2] ^ tr_hist);
        if (tr_tk && pht[idx] < 3) pht[idx]++;
        else if (!tr_tk && pht[idx] > 0) pht[idx]--;
      end
      if (tr_bv && tr_tk && tr_jt != JT_NONE) begin
        bi          = int'(tr_pc[BI+1:2]);
        btb_v[bi]   = 1'b1;
        btb_tag[bi] = tr_pc >> (BI + 2);
        btb_tgt[bi] = tr_tgt;
      end
      if (tr_push) begin
        ras.push_back(tr_data);
        if (ras.size() > RAS_DEPTH) void'(ras.pop_front());  // oldest falls out
      end
    end
    tr_bv      = ex_branch_valid_i;
    tr_tk      = ex_branch_taken_i;
    tr_jt      = ex_jump_type_i;
    tr_pc      = ex_pc_i;
    tr_tgt     = ex_target_i;
    tr_hist    = ex_history_i;
    tr_push    = id_ras_push_valid_i;
    tr_data    = id_ras_push_data_i;
    prev_stall = id_stall_i;
    prev_redir = ex_redirect_i;
    prev_pc    = id_pc_o;
    prev_inst  = id_inst_o;
    prev_misc  = misc;
    prev_word  = if_rdata_i;
  end

  always @(posedge done_i) begin
    for (int i = 0; i < N_TESTS; i++) begin
      $display("%-12s %s  pass %0d  fail %0d", names[i],
               (fail_cnt[i] == 0) ? "ok  " : "FAIL", pass_cnt[i], fail_cnt[i]);
    end
  end

endmodule

// ==== verif/fetch_properties.sv ====
`timescale 1ns/1ps

module fetch_properties (
  input logic                           clk,
  input logic                           rst_n_i,
  input logic                           stall_i,
  input logic                           flush_i,
  input logic                           id_valid_o,
  input logic                           id_pdt_taken_o,
  input logic [fetch_pkg::XLEN-1:0]     id_pc_o,
  input logic [fetch_pkg::XLEN-1:0]     id_inst_o,
  input logic [fetch_pkg::TRAP_LEN-1:0] id_trap_o
);

  int fail_cnt = 0;

  // a redirect always leaves a bubble behind
  a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
    flush_i |=> !id_valid_o)
    else begin
      $error("redirect did not load a bubble into IF/ID");
      fail_cnt++;
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i && !flush_i |=> $stable(id_valid_o) && $stable(id_pc_o) &&
                            $stable(id_inst_o) && $stable(id_trap_o))
    else begin
      $error("IF/ID changed while decode was stalled");
      fail_cnt++;
    end

  a_pdt_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    id_pdt_taken_o |-> id_valid_o)
    else begin
      $error("prediction flag set on a bubble");
      fail_cnt++;
    end

  a_trap_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
    !id_valid_o |-> id_trap_o == '0)
    else begin
      $error("trap bits set on a bubble");
      fail_cnt++;
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = '0,
  parameter int unsigned                HISLEN      = 8,
  parameter int unsigned                BTB_ENTRIES = 16,
  parameter int unsigned                RAS_DEPTH   = 4
) (
  input  logic                           clk,
  input  logic                           rst_n_i,
  output logic [fetch_pkg::XLEN-1:0]     inst_addr_o,    // to instruction memory
  input  logic [fetch_pkg::XLEN-1:0]     if_rdata_i,
  input  logic                           if_rdata_valid_i,
  input  logic                           ex_branch_valid_i,
  input  logic                           ex_branch_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]     ex_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]     ex_target_i,
  input  logic [HISLEN-1:0]              ex_history_i,
  input  fetch_pkg::jump_type_e          ex_jump_type_i,
  input  logic                           ex_redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]     ex_redirect_pc_i,
  input  logic                           id_ras_push_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]     id_ras_push_data_i,
  input  logic                           id_stall_i,
  output logic                           id_valid_o,
  output logic [fetch_pkg::XLEN-1:0]     id_pc_o,
  output logic [fetch_pkg::XLEN-1:0]     id_inst_o,
  output logic [fetch_pkg::TRAP_LEN-1:0] id_trap_o,
  output logic                           id_pdt_taken_o,
  output logic [HISLEN-1:0]              id_history_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0]     pc;
  logic                stall;
  logic                ram_stall;
  logic [XLEN-1:0]     bpu_pc;
  logic                bpu_pc_valid;
  logic [XLEN-1:0]     inst_data;
  logic [TRAP_LEN-1:0] trap_bus;
  logic                pdt_res;
  logic [HISLEN-1:0]   history;

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall),
    .redirect_i    (ex_redirect_i),
    .redirect_pc_i (ex_redirect_pc_i),
    .pdt_valid_i   (bpu_pc_valid),
    .pdt_pc_i      (bpu_pc),
    .pc_o          (pc)
  );

  ifu #(
    .HISLEN      (HISLEN),
    .BTB_ENTRIES (BTB_ENTRIES),
    .RAS_DEPTH   (RAS_DEPTH)
  ) u_ifu (
    .clk                  (clk),
    .rst_n_i              (rst_n_i),
    .inst_addr_i          (pc),
    .if_rdata_valid_i     (if_rdata_valid_i),
    .if_rdata_i           (if_rdata_i),
    .id_stall_i           (id_stall_i),
    .if_flush_i           (ex_redirect_i),
    .ex_branch_valid_i    (ex_branch_valid_i),
    .ex_branch_taken_i    (ex_branch_taken_i),
    .ex_pc_i              (ex_pc_i),
    .ex_history_i         (ex_history_i),
    .ex_jump_type_i       (ex_jump_type_i),
    .ex_target_i          (ex_target_i),
    .id_ras_push_valid_i  (id_ras_push_valid_i),
    .id_ras_push_data_i   (id_ras_push_data_i),
    .ram_stall_valid_if_o (ram_stall),
    .stall_o              (stall),
    .inst_addr_o          (inst_addr_o),
    .inst_data_o          (inst_data),
    .trap_bus_o           (trap_bus),
    .bpu_pc_o             (bpu_pc),
    .bpu_pc_valid_o       (bpu_pc_valid),
    .pdt_res_o            (pdt_res),
    .history_o            (history)
  );

  if_id_reg #(
    .HISLEN (HISLEN)
  ) u_if_id_reg (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .valid_i        (!ram_stall),
    .stall_i        (id_stall_i),
    .flush_i        (ex_redirect_i),
    .pc_i           (inst_addr_o),
    .inst_i         (inst_data),
    .trap_i         (trap_bus),
    .pdt_taken_i    (pdt_res),
    .history_i      (history),
    .id_valid_o     (id_valid_o),
    .id_pc_o        (id_pc_o),
    .id_inst_o      (id_inst_o),
    .id_trap_o      (id_trap_o),
    .id_pdt_taken_o (id_pdt_taken_o),
    .id_history_o   (id_history_o)
  );

endmodule

// ==== hw/if_id_reg.sv ====
`timescale 1ns/1ps

module if_id_reg #(
  parameter int unsigned HISLEN = 8
) (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic                           valid_i,      // fetch data present
  input  logic                           stall_i,      // decode back-pressure
  input  logic                           flush_i,      // execute redirect
  input  logic [fetch_pkg::XLEN-1:0]     pc_i,
  input  logic [fetch_pkg::XLEN-1:0]     inst_i,
  input  logic [fetch_pkg::TRAP_LEN-1:0] trap_i,
  input  logic                           pdt_taken_i,
  input  logic [HISLEN-1:0]              history_i,
  output logic                           id_valid_o,
  output logic [fetch_pkg::XLEN-1:0]     id_pc_o,
  output logic [fetch_pkg::XLEN-1:0]     id_inst_o,
  output logic [fetch_pkg::TRAP_LEN-1:0] id_trap_o,
  output logic                           id_pdt_taken_o,
  output logic [HISLEN-1:0]              id_history_o
);

  // flush wins over a decode stall, the held word is on the wrong path
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_valid_o     <= 1'b0;
      id_trap_o      <= '0;
      id_pdt_taken_o <= 1'b0;
    end else if (flush_i) begin
      id_valid_o     <= 1'b0;
      id_trap_o      <= '0;
      id_pdt_taken_o <= 1'b0;
    end else if (!stall_i) begin
      id_valid_o     <= valid_i;                    // bubble when memory stalls
      id_trap_o      <= valid_i ? trap_i : '0;
      id_pdt_taken_o <= valid_i && pdt_taken_i;
    end
  end

  // payload is don't-care while id_valid_o is low
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      id_pc_o      <= pc_i;
      id_inst_o    <= inst_i;
      id_history_o <= history_i;
    end
  end

endmodule

// ==== hw/ifu.sv ====
`timescale 1ns/1ps

module ifu #(
  parameter int unsigned HISLEN      = 8,
  parameter int unsigned BTB_ENTRIES = 16,
  parameter int unsigned RAS_DEPTH   = 4
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0]   inst_addr_i,   // from pc_gen
  input  logic                         if_rdata_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]   if_rdata_i,
  input  logic                         id_stall_i,
  input  logic                         if_flush_i,
  input  logic                         ex_branch_valid_i,
  input  logic                         ex_branch_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]   ex_pc_i,
  input  logic [HISLEN-1:0]            ex_history_i,
  input  fetch_pkg::jump_type_e        ex_jump_type_i,
  input  logic [fetch_pkg::XLEN-1:0]   ex_target_i,
  input  logic                         id_ras_push_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]   id_ras_push_data_i,
  output logic                         ram_stall_valid_if_o,
  output logic                         stall_o,
  output logic [fetch_pkg::XLEN-1:0]   inst_addr_o,
  output logic [fetch_pkg::XLEN-1:0]   inst_data_o,
  output logic [fetch_pkg::TRAP_LEN-1:0] trap_bus_o,
  output logic [fetch_pkg::XLEN-1:0]   bpu_pc_o,
  output logic                         bpu_pc_valid_o,
  output logic                         pdt_res_o,
  output logic [HISLEN-1:0]            history_o
);
  import fetch_pkg::*;

  logic                ram_stall;
  logic                misaligned;
  logic                pred_ok;
  logic                pdt_valid;
  logic                pdt_taken;
  logic [TRAP_LEN-1:0] trap_bus;

  assign ram_stall  = !if_rdata_valid_i;  // memory not ready yet
  assign misaligned = |inst_addr_i[1:0];
  assign pred_ok    = !ram_stall && !misaligned;
  assign stall_o    = ram_stall || id_stall_i;

  bpu #(
    .HISLEN      (HISLEN),
    .BTB_ENTRIES (BTB_ENTRIES),
    .RAS_DEPTH   (RAS_DEPTH)
  ) u_bpu (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .if_pc_i             (inst_addr_i),
    .if_inst_i           (if_rdata_i),
    .stall_i             (stall_o || misaligned),
    .flush_i             (if_flush_i),
    .ex_branch_valid_i   (ex_branch_valid_i),
    .ex_branch_taken_i   (ex_branch_taken_i),
    .ex_pc_i             (ex_pc_i),
    .ex_history_i        (ex_history_i),
    .ex_jump_type_i      (ex_jump_type_i),
    .ex_target_i         (ex_target_i),
    .id_ras_push_valid_i (id_ras_push_valid_i),
    .id_ras_push_data_i  (id_ras_push_data_i),
    .pdt_pc_o            (bpu_pc_o),
    .pdt_valid_o         (pdt_valid),
    .pdt_taken_o         (pdt_taken),
    .history_o           (history_o)
  );

  // no prediction from a word that is not really there
  assign bpu_pc_valid_o = pdt_valid && pred_ok;
  assign pdt_res_o      = pdt_taken && pred_ok;

  always_comb begin
    trap_bus                            = '0;
    trap_bus[TRAP_INST_ADDR_MISALIGNED] = misaligned;
    trap_bus[TRAP_INST_ACCESS_FAULT]    = 1'b0;  // no PMP here
    trap_bus[TRAP_INST_PAGE_FAULT]      = 1'b0;  // bare mode only
  end

  assign trap_bus_o           = trap_bus;
  assign ram_stall_valid_if_o = ram_stall;
  assign inst_addr_o          = inst_addr_i;
  assign inst_data_o          = if_rdata_i;

endmodule

// ==== hw/bpu.sv ====
`timescale 1ns/1ps

module bpu #(
  parameter int unsigned HISLEN      = 8,
  parameter int unsigned BTB_ENTRIES = 16,
  parameter int unsigned RAS_DEPTH   = 4
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0] if_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] if_inst_i,
  input  logic                       stall_i,     // fetch will repeat, keep state
  input  logic                       flush_i,     // execute redirect
  input  logic                       ex_branch_valid_i,
  input  logic                       ex_branch_taken_i,
  input  logic [fetch_pkg::XLEN-1:0] ex_pc_i,
  input  logic [HISLEN-1:0]          ex_history_i,
  input  fetch_pkg::jump_type_e      ex_jump_type_i,
  input  logic [fetch_pkg::XLEN-1:0] ex_target_i,
  input  logic                       id_ras_push_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] id_ras_push_data_i,
  output logic [fetch_pkg::XLEN-1:0] pdt_pc_o,
  output logic                       pdt_valid_o,
  output logic                       pdt_taken_o,
  output logic [HISLEN-1:0]          history_o
);
  import fetch_pkg::*;

  localparam int unsigned PHT_ENTRIES = 1 << HISLEN;
  localparam int unsigned BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int unsigned TAG_W       = XLEN - BTB_IDX_W - 2;
  localparam int unsigned RAS_PTR_W   = $clog2(RAS_DEPTH);
  localparam int unsigned RAS_CNT_W   = $clog2(RAS_DEPTH + 1);

  logic [1:0]             pht_q [PHT_ENTRIES];  // 2-bit saturating counters
  logic [HISLEN-1:0]      ghr_q;
  logic [BTB_ENTRIES-1:0] btb_valid_q;
  logic [TAG_W-1:0]       btb_tag_q [BTB_ENTRIES];
  logic [XLEN-1:0]        btb_target_q [BTB_ENTRIES];
  logic [XLEN-1:0]        ras_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0]   ras_ptr_q;            // next free slot
  logic [RAS_CNT_W-1:0]   ras_cnt_q;

  inst_class_e            cls;
  logic [XLEN-1:0]        j_imm;
  logic [HISLEN-1:0]      if_idx;
  logic [HISLEN-1:0]      ex_idx;
  logic [BTB_IDX_W-1:0]   if_btb_idx;
  logic [BTB_IDX_W-1:0]   ex_btb_idx;
  logic                   btb_hit;
  logic                   btb_we;
  logic [RAS_PTR_W-1:0]   ras_top;
  logic [RAS_PTR_W-1:0]   ras_ptr_nxt;
  logic                   ras_empty;
  logic                   ras_pop;
  logic                   update;
  logic                   pdt_taken;

  always_comb begin
    cls = CLS_OTHER;
    case (if_inst_i[6:0])
      OPC_BRANCH: cls = CLS_BRANCH;
      OPC_JAL:    cls = CLS_JAL;
      OPC_JALR: begin
        if (if_inst_i[19:15] == REG_RA && if_inst_i[11:7] == REG_ZERO) begin
          cls = CLS_JALR_RET;
        end else begin
          cls = CLS_JALR;
        end
      end
      default:    cls = CLS_OTHER;
    endcase
  end

  assign j_imm = {{(XLEN-20){if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                  if_inst_i[30:21], 1'b0};

  assign if_idx     = if_pc_i[HISLEN+1:2] ^ ghr_q;  // gshare hash
  assign ex_idx     = ex_pc_i[HISLEN+1:2] ^ ex_history_i;
  assign if_btb_idx = if_pc_i[BTB_IDX_W+1:2];
  assign ex_btb_idx = ex_pc_i[BTB_IDX_W+1:2];
  assign btb_hit    = btb_valid_q[if_btb_idx] &&
                      btb_tag_q[if_btb_idx] == if_pc_i[XLEN-1:BTB_IDX_W+2];

  assign ras_empty   = (ras_cnt_q == '0);
  assign ras_top     = (ras_ptr_q == '0) ? RAS_PTR_W'(RAS_DEPTH - 1) : ras_ptr_q - 1'b1;
  assign ras_ptr_nxt = (ras_ptr_q == RAS_PTR_W'(RAS_DEPTH - 1)) ? '0 : ras_ptr_q + 1'b1;

  always_comb begin
    pdt_taken = 1'b0;
    pdt_pc_o  = if_pc_i + j_imm;
    case (cls)
      CLS_JAL:      pdt_taken = 1'b1;
      CLS_BRANCH: begin
        pdt_taken = pht_q[if_idx][1] && btb_hit;  // counter >= 2
        pdt_pc_o  = btb_target_q[if_btb_idx];
      end
      CLS_JALR_RET: begin
        pdt_taken = !ras_empty;
        pdt_pc_o  = ras_q[ras_top];
      end
      default:      pdt_taken = 1'b0;  // plain jalr waits for execute
    endcase
  end

  assign pdt_valid_o = pdt_taken;
  assign pdt_taken_o = pdt_taken;
  assign history_o   = ghr_q;

  // speculative state only moves on a fetch that goes forward
  assign update  = !stall_i && !flush_i;
  assign ras_pop = update && cls == CLS_JALR_RET && !ras_empty;
  assign btb_we  = ex_branch_valid_i && ex_branch_taken_i && ex_jump_type_i != JT_NONE;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht_q[i] <= 2'b01;  // weakly not taken
      end
    end else if (ex_branch_valid_i && ex_jump_type_i == JT_BRANCH) begin
      if (ex_branch_taken_i && pht_q[ex_idx] != 2'b11) begin
        pht_q[ex_idx] <= pht_q[ex_idx] + 2'd1;
      end else if (!ex_branch_taken_i && pht_q[ex_idx] != 2'b00) begin
        pht_q[ex_idx] <= pht_q[ex_idx] - 2'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ghr_q <= '0;
    end else if (flush_i) begin
      ghr_q <= ex_history_i;  // back to the history execute saw
    end else if (update && cls == CLS_BRANCH) begin
      ghr_q <= {ghr_q[HISLEN-2:0], pdt_taken};
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      btb_valid_q <= '0;
    end else if (btb_we) begin
      btb_valid_q[ex_btb_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (btb_we) begin
      btb_tag_q[ex_btb_idx]    <= ex_pc_i[XLEN-1:BTB_IDX_W+2];
      btb_target_q[ex_btb_idx] <= ex_target_i;
    end
  end

  // circular stack, a push into a full stack overwrites the oldest slot
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ras_ptr_q <= '0;
      ras_cnt_q <= '0;
    end else if (id_ras_push_valid_i && !ras_pop) begin
      ras_ptr_q <= ras_ptr_nxt;
      if (ras_cnt_q != RAS_CNT_W'(RAS_DEPTH)) begin
        ras_cnt_q <= ras_cnt_q + 1'b1;
      end
    end else if (ras_pop && !id_ras_push_valid_i) begin
      ras_ptr_q <= ras_top;
      ras_cnt_q <= ras_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (id_ras_push_valid_i && ras_pop) begin
      ras_q[ras_top] <= id_ras_push_data_i;  // pop and push swap the top
    end else if (id_ras_push_valid_i) begin
      ras_q[ras_ptr_q] <= id_ras_push_data_i;
    end
  end

endmodule

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       stall_i,        // memory or decode stall
  input  logic                       redirect_i,     // execute redirect strobe
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                       pdt_valid_i,    // predictor wants a jump
  input  logic [fetch_pkg::XLEN-1:0] pdt_pc_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic [XLEN-1:0] pc_seq;

  assign pc_seq = pc_q + XLEN'(4);

  // redirect beats everything, a stalled fetch simply repeats
  always_comb begin
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (stall_i) begin
      pc_d = pc_q;
    end else if (pdt_valid_i) begin
      pc_d = pdt_pc_i;
    end else begin
      pc_d = pc_seq;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  // data and address width
  localparam int unsigned XLEN = 32;

  // trap vector handed to decode
  localparam int unsigned TRAP_LEN = 16;

  // trap bit positions, numbered after the mcause exception codes
  localparam int unsigned TRAP_INST_ADDR_MISALIGNED = 0;
  localparam int unsigned TRAP_INST_ACCESS_FAULT    = 1;
  localparam int unsigned TRAP_INST_PAGE_FAULT      = 12;

  // major opcodes the predictor cares about
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // register numbers for return detection
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;  // x1, link register

  // class of the word sitting in the fetch stage
  typedef enum logic [2:0] {
    CLS_OTHER,     // anything that falls through
    CLS_BRANCH,    // conditional branch
    CLS_JAL,       // direct jump
    CLS_JALR_RET,  // jalr x0, 0(x1)
    CLS_JALR       // other indirect jumps
  } inst_class_e;

  // jump kind reported by execute
  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

endpackage
